// ==== files.f ====
+incdir+include
hw/ising_pkg.sv
hw/ising_jmem_if.sv
hw/ising_csr.sv
hw/ising_jmem.sv
hw/ising_sweep_ctrl.sv
hw/ising_field_unit.sv
hw/ising_core_top.sv
dv/tb_ising_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the Ising core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    -f files.f \
    --top-module tb_ising_core \
    -o sim_ising

./obj_dir/sim_ising | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"

// ==== dv/tb_ising_core.sv ====
//////////////////////////////////////////////////////////////////////
// Drives the core over APB and checks it against a behavioral model
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "ising_defines.svh"

module tb_ising_core;
    import ising_pkg::*;

    localparam int CLK_HALF   = 10;
    localparam int CLK_PERIOD = 2 * CLK_HALF;
    localparam int NSPIN      = `ISING_NUM_SPIN;
    localparam int NUM_CASES  = 6;

    // Case table of J seed, initial spins, sweep count and writes while busy
    localparam logic [31:0] CASE_JSEED [NUM_CASES] =
        '{32'h1234abcd, 32'h0badf00d, 32'h7e57c0de, 32'h55aa33cc, 32'h9e3779b9, 32'h31415926};
    localparam logic [7:0]  CASE_SPINS [NUM_CASES] =
        '{8'ha5, 8'h3c, 8'h96, 8'h0f, 8'hd2, 8'h41};
    localparam int          CASE_SWEEPS [NUM_CASES] = '{0, 1, 2, 3, 4, 2};
    localparam bit          CASE_POKE [NUM_CASES]   = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};

    logic       clk = 1'b0;
    logic       reset_i;
    apb_addr_t  paddr;
    logic       psel, penable, pwrite;
    apb_data_t  pwdata;
    apb_data_t  prdata_o;
    logic       pready_o, pslverr_o, done_o;

    logic signed [3:0] jm [NSPIN][NSPIN];
    int errors = 0;
    int checks = 0;

    ising_core_top u_dut (
        .clk_i     (clk),
        .reset_i   (reset_i),
        .paddr_i   (paddr),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .done_o    (done_o)
    );

    always #CLK_HALF clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // APB accesses with one idle cycle between them
    //////////////////////////////////////////////////////////////////////
    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b1;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_HALF / 2);
        err = pslverr_o;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_HALF / 2);
        data = prdata_o;
        err  = pslverr_o;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Local field of row i with the diagonal skipped
    function automatic int field_of(input int i, input logic [7:0] s);
        int h = 0;
        for (int j = 0; j < NSPIN; j++) begin
            if (j != i)
                h += s[j] ? int'(jm[i][j]) : -int'(jm[i][j]);
        end
        return h;
    endfunction

    task automatic model_run(input logic [7:0] s0, input int sweeps,
                             output logic [7:0] s, output int e);
        int h;
        s = s0;
        for (int k = 0; k < sweeps; k++) begin
            for (int i = 0; i < NSPIN; i++) begin
                h = field_of(i, s);
                if (h > 0)
                    s[i] = 1'b1;
                else if (h < 0)
                    s[i] = 1'b0;
            end
        end
        e = 0;
        for (int i = 0; i < NSPIN; i++) begin
            h = field_of(i, s);
            e -= s[i] ? h : -h;
        end
    endtask

    // Random symmetric J with a random diagonal
    task automatic load_random_j(input int c);
        logic [31:0] r;
        apb_data_t   row;
        logic        err;
        for (int i = 0; i < NSPIN; i++) begin
            for (int j = i; j < NSPIN; j++) begin
                r = $urandom() ^ (CASE_JSEED[c] >> (4 * j));
                jm[i][j] = r[3:0];
                jm[j][i] = r[3:0];
            end
        end
        for (int i = 0; i < NSPIN; i++) begin
            for (int j = 0; j < NSPIN; j++)
                row[4*j +: 4] = jm[i][j];
            apb_write(`REG_J_BASE + apb_addr_t'(4 * i), row, err);
            check("pslverr_o", err, 0);
        end
    endtask

    task automatic run_case(input int c);
        apb_data_t  rdata;
        logic       err;
        logic [7:0] exp_spins;
        int         exp_energy;
        int         sweeps;
        sweeps = CASE_SWEEPS[c];
        load_random_j(c);
        apb_write(`REG_SPIN, apb_data_t'(CASE_SPINS[c]), err);
        check("pslverr_o", err, 0);
        model_run(CASE_SPINS[c], sweeps, exp_spins, exp_energy);
        // Stale zero count ahead of the start
        apb_write(`REG_CTRL, 32'h0, err);
        check("pslverr_o", err, 0);
        check("done_o", done_o, (c > 0) ? 1 : 0);
        apb_write(`REG_CTRL, apb_data_t'((sweeps << 8) | 1), err);
        check("pslverr_o", err, 0);
        // Accepted start clears done
        apb_read(`REG_STATUS, rdata, err);
        check("STATUS", rdata, 32'h1);
        check("done_o", done_o, 0);
        if (CASE_POKE[c]) begin
            apb_write(`REG_SPIN, apb_data_t'(~CASE_SPINS[c]), err);
            check("pslverr_o", err, 1);
            apb_write(`REG_J_BASE + 8'h0c, 32'h7777_7777, err);
            check("pslverr_o", err, 1);
            apb_write(`REG_CTRL, apb_data_t'((sweeps << 8) | 1), err);
            check("pslverr_o", err, 1);
        end
        do begin
            apb_read(`REG_STATUS, rdata, err);
            if (!rdata[1])
                check("STATUS.busy", rdata[0], 1);
        end while (!rdata[1]);
        check("STATUS", rdata, 32'h2);
        check("done_o", done_o, 1);
        apb_read(`REG_SPIN, rdata, err);
        check("SPIN", rdata, apb_data_t'(exp_spins));
        apb_read(`REG_ENERGY, rdata, err);
        check("ENERGY", rdata, exp_energy);
        apb_read(`REG_CTRL, rdata, err);
        check("CTRL", rdata, apb_data_t'(sweeps << 8));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        apb_data_t rdata;
        logic      err;
        reset_i = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        void'($urandom(32'h5f9b23aa));
        repeat (10) @(negedge clk);
        reset_i = 1'b0;

        apb_read(`REG_STATUS, rdata, err);
        check("STATUS", rdata, 0);
        apb_read(`REG_SPIN, rdata, err);
        check("SPIN", rdata, 0);
        apb_read(`REG_ENERGY, rdata, err);
        check("ENERGY", rdata, 0);
        check("done_o", done_o, 0);
        check("pready_o", pready_o, 1);
        apb_read(8'h20, rdata, err);
        check("pslverr_o", err, 1);
        check("prdata_o", rdata, 0);
        apb_write(`REG_SPIN, 32'h5a, err);
        apb_read(`REG_SPIN, rdata, err);
        check("SPIN", rdata, 32'h5a);

        for (int c = 0; c < NUM_CASES; c++)
            run_case(c);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // Watchdog sized from the case table
    initial begin
        int limit;
        limit = 10 + 3 * 10;
        for (int c = 0; c < NUM_CASES; c++)
            limit += 2 * NSPIN * (CASE_SWEEPS[c] + 1) + 40 + 3 * 24;
        #(limit * CLK_PERIOD);
        $display("Timeout: run did not finish in %0d cycles, controller state %s",
                 limit, u_dut.u_ctrl.state_q.name());
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/ising_core_top.sv ====
//////////////////////////////////////////////////////////////////////
// Plain APB slave ports; pready is tied high
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module ising_core_top (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  ising_pkg::apb_addr_t  paddr_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  ising_pkg::apb_data_t  pwdata_i,
    output ising_pkg::apb_data_t  prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    output logic                  done_o
);
    import ising_pkg::*;

    logic       j_we;
    spin_idx_t  j_waddr;
    j_row_t     j_wdata;
    logic       start;
    sweep_cnt_t sweep_count;
    logic       busy;
    logic       done_pulse;
    logic       spin_load;
    spin_vec_t  spin_wdata;
    spin_vec_t  spins;
    energy_t    energy;
    spin_idx_t  row_idx;
    logic       update_phase;
    logic       energy_phase;
    logic       energy_clr;

    ising_jmem_if jmem_rd ();

    ising_csr u_csr (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .paddr_i       (paddr_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .j_we_o        (j_we),
        .j_waddr_o     (j_waddr),
        .j_wdata_o     (j_wdata),
        .start_o       (start),
        .sweep_count_o (sweep_count),
        .busy_i        (busy),
        .done_pulse_i  (done_pulse),
        .spin_load_o   (spin_load),
        .spin_wdata_o  (spin_wdata),
        .spins_i       (spins),
        .energy_i      (energy),
        .done_o        (done_o)
    );

    ising_jmem u_jmem (
        .clk_i   (clk_i),
        .we_i    (j_we),
        .waddr_i (j_waddr),
        .wdata_i (j_wdata),
        .rd      (jmem_rd.responder)
    );

    ising_sweep_ctrl u_ctrl (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .start_i        (start),
        .sweep_count_i  (sweep_count),
        .busy_o         (busy),
        .done_pulse_o   (done_pulse),
        .rd             (jmem_rd.requester),
        .row_idx_o      (row_idx),
        .update_phase_o (update_phase),
        .energy_phase_o (energy_phase),
        .energy_clr_o   (energy_clr)
    );

    ising_field_unit u_field (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .rd             (jmem_rd.observer),
        .row_idx_i      (row_idx),
        .update_phase_i (update_phase),
        .energy_phase_i (energy_phase),
        .energy_clr_i   (energy_clr),
        .spin_load_i    (spin_load),
        .spin_wdata_i   (spin_wdata),
        .spins_o        (spins),
        .energy_o       (energy)
    );

endmodule

`default_nettype wire

// ==== hw/ising_field_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Diagonal weight ignored; field of zero leaves the spin unchanged
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "ising_defines.svh"

module ising_field_unit (
    input  logic                  clk_i,
    input  logic                  reset_i,
    ising_jmem_if.observer        rd,
    input  ising_pkg::spin_idx_t  row_idx_i,
    input  logic                  update_phase_i,
    input  logic                  energy_phase_i,
    input  logic                  energy_clr_i,
    input  logic                  spin_load_i,
    input  ising_pkg::spin_vec_t  spin_wdata_i,
    output ising_pkg::spin_vec_t  spins_o,
    output ising_pkg::energy_t    energy_o
);
    import ising_pkg::*;

    spin_vec_t spins_q;
    energy_t   energy_q;
    field_t    h_sum;
    energy_t   e_delta;
    logic      s_i;

    //////////////////////////////////////////////////////////////////////
    // Local field of the returned row
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        j_elem_t w;
        h_sum = '0;
        for (int j = 0; j < `ISING_NUM_SPIN; j++) begin
            w = rd.rdata[j*`ISING_J_BITS +: `ISING_J_BITS];
            if (spin_idx_t'(j) != row_idx_i) begin
                if (spins_q[j])
                    h_sum = h_sum + field_t'(w);
                else
                    h_sum = h_sum - field_t'(w);
            end
        end
    end

    assign s_i = spins_q[row_idx_i];

    // Term -s_i * h_i
    assign e_delta = s_i ? -energy_t'(h_sum) : energy_t'(h_sum);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            spins_q <= '0;
        end else if (spin_load_i) begin
            spins_q <= spin_wdata_i;
        end else if (rd.rvalid && update_phase_i) begin
            if (h_sum > 0)
                spins_q[row_idx_i] <= 1'b1;
            else if (h_sum < 0)
                spins_q[row_idx_i] <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || energy_clr_i)
            energy_q <= '0;
        else if (rd.rvalid && energy_phase_i)
            energy_q <= energy_q + e_delta;
    end

    assign spins_o  = spins_q;
    assign energy_o = energy_q;

endmodule

`default_nettype wire

// ==== hw/ising_sweep_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// Two cycles per row; a sweep count of zero runs only the energy pass
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "ising_defines.svh"

module ising_sweep_ctrl (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   start_i,
    input  ising_pkg::sweep_cnt_t  sweep_count_i,
    output logic                   busy_o,
    output logic                   done_pulse_o,
    ising_jmem_if.requester        rd,
    output ising_pkg::spin_idx_t   row_idx_o,
    output logic                   update_phase_o,
    output logic                   energy_phase_o,
    output logic                   energy_clr_o
);
    import ising_pkg::*;

    ctrl_state_t state_q;
    spin_idx_t   row_q;
    sweep_cnt_t  sweeps_left_q;
    logic        last_row;

    assign last_row = (row_q == spin_idx_t'(`ISING_NUM_SPIN - 1));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q       <= IDLE;
            row_q         <= '0;
            sweeps_left_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        row_q         <= '0;
                        sweeps_left_q <= sweep_count_i;
                        state_q       <= (sweep_count_i == '0) ? ENERGY_RD : SWEEP_RD;
                    end
                end
                SWEEP_RD:  state_q <= SWEEP_UPD;
                SWEEP_UPD: begin
                    row_q <= row_q + 1'b1;
                    if (!last_row)
                        state_q <= SWEEP_RD;
                    else if (sweeps_left_q == sweep_cnt_t'(1))
                        state_q <= ENERGY_RD;
                    else begin
                        sweeps_left_q <= sweeps_left_q - 1'b1;
                        state_q       <= SWEEP_RD;
                    end
                end
                ENERGY_RD:  state_q <= ENERGY_ACC;
                ENERGY_ACC: begin
                    row_q   <= row_q + 1'b1;
                    state_q <= last_row ? FINISH : ENERGY_RD;
                end
                FINISH:  state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // Row reads and phase strobes
    assign rd.ren         = (state_q == SWEEP_RD) || (state_q == ENERGY_RD);
    assign rd.raddr       = row_q;
    assign row_idx_o      = row_q;
    assign update_phase_o = (state_q == SWEEP_UPD);
    assign energy_phase_o = (state_q == ENERGY_ACC);
    assign energy_clr_o   = start_i && (state_q == IDLE);

    assign busy_o       = (state_q != IDLE);
    assign done_pulse_o = (state_q == FINISH);

endmodule

`default_nettype wire

// ==== hw/ising_jmem.sv ====
//////////////////////////////////////////////////////////////////////
// Rows hold no reset value and are undefined until written
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "ising_defines.svh"

module ising_jmem (
    input  logic                  clk_i,
    input  logic                  we_i,
    input  ising_pkg::spin_idx_t  waddr_i,
    input  ising_pkg::j_row_t     wdata_i,
    ising_jmem_if.responder       rd
);
    import ising_pkg::*;

    j_row_t mem [`ISING_NUM_SPIN];
    j_row_t rdata_q;
    logic   rvalid_q;

    // Host load path
    always_ff @(posedge clk_i) begin
        if (we_i)
            mem[waddr_i] <= wdata_i;
    end

    // Engine read path with one cycle latency
    always_ff @(posedge clk_i) begin
        rvalid_q <= rd.ren;
        if (rd.ren)
            rdata_q <= mem[rd.raddr];
    end

    assign rd.rdata  = rdata_q;
    assign rd.rvalid = rvalid_q;

endmodule

`default_nettype wire

// ==== hw/ising_csr.sv ====
//////////////////////////////////////////////////////////////////////
// APB slave with zero wait states; J window is write-only
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "ising_defines.svh"

module ising_csr (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  ising_pkg::apb_addr_t    paddr_i,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  ising_pkg::apb_data_t    pwdata_i,
    output ising_pkg::apb_data_t    prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,
    output logic                    j_we_o,
    output ising_pkg::spin_idx_t    j_waddr_o,
    output ising_pkg::j_row_t       j_wdata_o,
    output logic                    start_o,
    output ising_pkg::sweep_cnt_t   sweep_count_o,
    input  logic                    busy_i,
    input  logic                    done_pulse_i,
    output logic                    spin_load_o,
    output ising_pkg::spin_vec_t    spin_wdata_o,
    input  ising_pkg::spin_vec_t    spins_i,
    input  ising_pkg::energy_t      energy_i,
    output logic                    done_o
);
    import ising_pkg::*;

    logic       acc_wr;
    logic       acc_rd;
    logic       is_ctrl, is_status, is_spin, is_energy, is_j;
    logic       mapped;
    logic       err;
    apb_addr_t  j_off;
    sweep_cnt_t sweep_count_q;
    logic       done_q;

    assign acc_wr = psel_i & penable_i & pwrite_i;
    assign acc_rd = psel_i & penable_i & ~pwrite_i;

    //////////////////////////////////////////////////////////////////////
    // Address decode and access checks
    //////////////////////////////////////////////////////////////////////
    assign j_off     = paddr_i - `REG_J_BASE;
    assign is_ctrl   = (paddr_i == `REG_CTRL);
    assign is_status = (paddr_i == `REG_STATUS);
    assign is_spin   = (paddr_i == `REG_SPIN);
    assign is_energy = (paddr_i == `REG_ENERGY);
    assign is_j      = (paddr_i >= `REG_J_BASE) && (j_off < 4 * `ISING_NUM_SPIN)
                       && (paddr_i[1:0] == 2'b00);
    assign mapped    = is_ctrl | is_status | is_spin | is_energy | is_j;

    // Busy core rejects reloads and restarts
    assign err = psel_i & penable_i &
                 (~mapped
                  | (acc_wr & busy_i & (is_spin | is_j))
                  | (acc_wr & busy_i & is_ctrl & pwdata_i[0]));

    assign pready_o  = 1'b1;
    assign pslverr_o = err;

    assign start_o       = acc_wr & is_ctrl & pwdata_i[0] & ~err;
    assign j_we_o        = acc_wr & is_j & ~err;
    assign j_waddr_o     = j_off[2 +: $bits(spin_idx_t)];
    assign j_wdata_o     = pwdata_i;
    assign spin_load_o   = acc_wr & is_spin & ~err;
    assign spin_wdata_o  = pwdata_i[`ISING_NUM_SPIN-1:0];
    // A start write carries its own count
    assign sweep_count_o = start_o ? pwdata_i[15:8] : sweep_count_q;
    assign done_o        = done_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sweep_count_q <= '0;
            done_q        <= 1'b0;
        end else begin
            if (acc_wr & is_ctrl & ~err)
                sweep_count_q <= pwdata_i[15:8];
            // Sticky until the next accepted start
            if (start_o)
                done_q <= 1'b0;
            else if (done_pulse_i)
                done_q <= 1'b1;
        end
    end

    // Read data
    always_comb begin
        prdata_o = '0;
        if (acc_rd) begin
            if (is_ctrl)
                prdata_o[15:8] = sweep_count_q;
            else if (is_status)
                prdata_o[1:0] = {done_q, busy_i};
            else if (is_spin)
                prdata_o[`ISING_NUM_SPIN-1:0] = spins_i;
            else if (is_energy)
                prdata_o = apb_data_t'(energy_i);
        end
    end

endmodule

`default_nettype wire

// ==== hw/ising_jmem_if.sv ====
//////////////////////////////////////////////////////////////////////
// Read port only; rdata and rvalid follow ren by exactly one cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

interface ising_jmem_if;

    logic                  ren;
    ising_pkg::spin_idx_t  raddr;
    ising_pkg::j_row_t     rdata;
    logic                  rvalid;

    modport requester (output ren, output raddr);
    modport responder (input ren, input raddr, output rdata, output rvalid);
    modport observer  (input rdata, input rvalid);

endinterface

`default_nettype wire

// ==== hw/ising_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Spin bit 1 is +1 and 0 is -1; J row element j sits at bits 4j+3:4j
//////////////////////////////////////////////////////////////////////
`default_nettype none

`include "ising_defines.svh"

package ising_pkg;

    typedef logic [`ISING_NUM_SPIN-1:0]                spin_vec_t;
    typedef logic signed [`ISING_J_BITS-1:0]           j_elem_t;
    typedef logic [`ISING_NUM_SPIN*`ISING_J_BITS-1:0]  j_row_t;
    typedef logic [$clog2(`ISING_NUM_SPIN)-1:0]        spin_idx_t;
    typedef logic signed [`ISING_FIELD_BITS-1:0]       field_t;
    typedef logic signed [`ISING_ENERGY_BITS-1:0]      energy_t;
    typedef logic [`ISING_SWEEP_BITS-1:0]              sweep_cnt_t;
    typedef logic [`APB_ADDR_BITS-1:0]                 apb_addr_t;
    typedef logic [`APB_DATA_BITS-1:0]                 apb_data_t;

    // Run sequencer states
    typedef enum logic [2:0] {
        IDLE,
        SWEEP_RD,
        SWEEP_UPD,
        ENERGY_RD,
        ENERGY_ACC,
        FINISH
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== include/ising_defines.svh ====
//////////////////////////////////////////////////////////////////////
// Sizes assume 8 spins with 4-bit couplings and one 32-bit row per spin
//////////////////////////////////////////////////////////////////////
`ifndef ISING_DEFINES_SVH
`define ISING_DEFINES_SVH

`define ISING_NUM_SPIN    8
`define ISING_J_BITS      4
`define ISING_SWEEP_BITS  8
`define ISING_FIELD_BITS  8
`define ISING_ENERGY_BITS 16

`define APB_ADDR_BITS 8
`define APB_DATA_BITS 32

// Register map with J row i at REG_J_BASE + 4*i
`define REG_CTRL   8'h00
`define REG_STATUS 8'h04
`define REG_SPIN   8'h08
`define REG_ENERGY 8'h0C
`define REG_J_BASE 8'h40

`endif
